/* common/noc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and sizes for the mesh router
// Flit layout, tile coordinates, port indices
// Referenced by scoped names from RTL and testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package noc_pkg;

  // Eject port plus four mesh directions
  localparam int unsigned NumPorts = 5;

  // Width of a port index
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);

  // Coordinate bits, enough for an 8 by 8 mesh
  localparam int unsigned CoordWidth = 3;

  // Payload bits carried by each flit
  localparam int unsigned PayloadWidth = 16;

  // Entries in each input queue
  localparam int unsigned FifoDepth = 2;

  // Port indices
  // South and North move along y, West and East along x
  typedef enum logic [2:0] {
    Eject = 3'd0,
    South = 3'd1,
    West  = 3'd2,
    North = 3'd3,
    East  = 3'd4
  } port_e;

  // Tile position in the mesh
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_coord_t;

  // One flit on a link
  typedef struct packed {
    // Destination tile carried by every flit
    xy_coord_t               dst;
    logic [PayloadWidth-1:0] payload;
    // Final flit of a packet
    logic                    last;
  } flit_t;

  // One-hot output choice
  typedef logic [NumPorts-1:0] route_t;

endpackage

`default_nettype wire

/* src/noc_input_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry flit queue for one router input
// Valid/ready on the link side, head and pop
// on the crossbar side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_input_fifo (
  input  logic           clk_i,
  input  logic           reset_i,
  input  noc_pkg::flit_t push_flit_i,
  input  logic           push_valid_i,
  output logic           push_ready_o,
  output noc_pkg::flit_t head_flit_o,
  output logic           head_valid_o,
  input  logic           pop_i
);

  // Flit storage
  noc_pkg::flit_t mem_q [noc_pkg::FifoDepth];

  logic [$clog2(noc_pkg::FifoDepth)-1:0]   rd_ptr_q;
  logic [$clog2(noc_pkg::FifoDepth)-1:0]   wr_ptr_q;
  logic [$clog2(noc_pkg::FifoDepth+1)-1:0] count_q;

  logic push;
  logic pop;

  // Ready depends only on fill level, never on pop
  // so a stalled output never reaches the link combinationally
  assign push_ready_o = (count_q != noc_pkg::FifoDepth);
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  // Pop of an empty queue is ignored
  assign pop  = pop_i & head_valid_o;

  // Write side
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_flit_i;
    end
  end

  // Pointers and fill count
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == noc_pkg::FifoDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::FifoDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/noc_route_select.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XY route decode for one router input
// One-hot request per head flit, held for
// the rest of the packet once it starts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_route_select (
  input  logic               clk_i,
  input  logic               reset_i,
  input  noc_pkg::xy_coord_t xy_id_i,
  input  noc_pkg::flit_t     head_flit_i,
  input  logic               head_valid_i,
  input  logic               pop_i,
  output noc_pkg::route_t    route_o
);

  noc_pkg::xy_coord_t dst;
  noc_pkg::route_t    route_dec;
  noc_pkg::route_t    route_q;

  logic lock_q;
  logic lock_d;

  assign dst = head_flit_i.dst;

  // Dimension order resolves x first, then y
  always_comb begin
    route_dec = '0;
    if (dst == xy_id_i) begin
      // Destination reached so leave through the local port
      route_dec[noc_pkg::Eject] = 1'b1;
    end else if (dst.x == xy_id_i.x) begin
      // Same column so move along y
      if (dst.y < xy_id_i.y) begin
        route_dec[noc_pkg::South] = 1'b1;
      end else begin
        route_dec[noc_pkg::North] = 1'b1;
      end
    end else begin
      // Different column so move along x
      if (dst.x < xy_id_i.x) begin
        route_dec[noc_pkg::West] = 1'b1;
      end else begin
        route_dec[noc_pkg::East] = 1'b1;
      end
    end
  end

  // Lock opens on a non-last pop, closes on the last one
  always_comb begin
    lock_d = lock_q;
    if (pop_i) begin
      lock_d = ~head_flit_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Track the fresh decode until a packet starts
  // then freeze it for the remaining flits
  always_ff @(posedge clk_i) begin
    if (!lock_q) begin
      route_q <= route_dec;
    end
  end

  // No request without a head flit
  always_comb begin
    if (!head_valid_i) begin
      route_o = '0;
    end else if (lock_q) begin
      route_o = route_q;
    end else begin
      route_o = route_dec;
    end
  end

endmodule

`default_nettype wire

/* src/noc_packet_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for one router output
// Grant is held from first flit to last flit
// so packets never interleave on the output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_packet_arbiter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [noc_pkg::NumPorts-1:0] req_i,
  input  logic [noc_pkg::NumPorts-1:0] last_i,
  input  logic                         out_ready_i,
  output logic [noc_pkg::NumPorts-1:0] gnt_o
);

  logic [noc_pkg::NumPorts-1:0] gnt_rr;
  logic [noc_pkg::NumPorts-1:0] gnt_q;

  logic [noc_pkg::PortIdxWidth-1:0] ptr_q;
  logic [noc_pkg::PortIdxWidth-1:0] ptr_d;

  logic lock_q;
  logic lock_d;
  logic out_valid;
  logic xfer;
  logic xfer_last;

  // Search upward from the pointer with wrap-around
  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_rr = '0;
    found  = 1'b0;
    for (int unsigned off = 0; off < noc_pkg::NumPorts; off++) begin
      idx = ptr_q + off;
      if (idx >= noc_pkg::NumPorts) begin
        idx = idx - noc_pkg::NumPorts;
      end
      if (req_i[idx] && !found) begin
        gnt_rr[idx] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  // Held grant wins over the fresh search
  assign gnt_o = lock_q ? gnt_q : gnt_rr;

  assign out_valid = |(gnt_o & req_i);
  assign xfer      = out_valid & out_ready_i;
  assign xfer_last = |(gnt_o & req_i & last_i);

  // Hold also while the output is stalled, keeping the offered flit stable
  // Release only once the last flit has gone through
  always_comb begin
    lock_d = lock_q;
    if (out_valid) begin
      lock_d = ~(xfer & xfer_last);
    end
  end

  // Advance past the winner at the end of a packet
  always_comb begin
    int unsigned win;
    win   = 0;
    ptr_d = ptr_q;
    for (int unsigned i = 0; i < noc_pkg::NumPorts; i++) begin
      if (gnt_o[i]) begin
        win = i;
      end
    end
    if (xfer && xfer_last) begin
      if (win == noc_pkg::NumPorts - 1) begin
        ptr_d = '0;
      end else begin
        ptr_d = noc_pkg::PortIdxWidth'(win + 1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      // Start the search at the local port
      ptr_q  <= noc_pkg::Eject;
    end else begin
      lock_q <= lock_d;
      ptr_q  <= ptr_d;
    end
  end

  // Follows the grant, frozen while locked
  always_ff @(posedge clk_i) begin
    gnt_q <= gnt_o;
  end

endmodule

`default_nettype wire

/* router/noc_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Five-port XY mesh router
// Input queues, route selection, per-output
// packet arbiters and the crossbar
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_router (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  // Coordinates of this tile
  input  noc_pkg::xy_coord_t                             xy_id_i,
  // Input channels, indexed by port_e
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0]         in_flit_i,
  input  logic           [noc_pkg::NumPorts-1:0]         in_valid_i,
  output logic           [noc_pkg::NumPorts-1:0]         in_ready_o,
  // Output channels, indexed by port_e
  output noc_pkg::flit_t [noc_pkg::NumPorts-1:0]         out_flit_o,
  output logic           [noc_pkg::NumPorts-1:0]         out_valid_o,
  input  logic           [noc_pkg::NumPorts-1:0]         out_ready_i
);

  // Per input
  noc_pkg::flit_t  [noc_pkg::NumPorts-1:0] head_flit;
  logic            [noc_pkg::NumPorts-1:0] head_valid;
  logic            [noc_pkg::NumPorts-1:0] head_last;
  logic            [noc_pkg::NumPorts-1:0] pop;
  noc_pkg::route_t [noc_pkg::NumPorts-1:0] route;

  // One bit per input for each output
  logic [noc_pkg::NumPorts-1:0][noc_pkg::NumPorts-1:0] out_req;
  logic [noc_pkg::NumPorts-1:0][noc_pkg::NumPorts-1:0] gnt;

  for (genvar i = 0; i < noc_pkg::NumPorts; i++) begin : gen_input

    noc_input_fifo u_fifo (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .push_flit_i  (in_flit_i[i]),
      .push_valid_i (in_valid_i[i]),
      .push_ready_o (in_ready_o[i]),
      .head_flit_o  (head_flit[i]),
      .head_valid_o (head_valid[i]),
      .pop_i        (pop[i])
    );

    noc_route_select u_route (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .xy_id_i      (xy_id_i),
      .head_flit_i  (head_flit[i]),
      .head_valid_i (head_valid[i]),
      .pop_i        (pop[i]),
      .route_o      (route[i])
    );

    assign head_last[i] = head_flit[i].last;

  end

  for (genvar o = 0; o < noc_pkg::NumPorts; o++) begin : gen_output

    // Gather the request bit of every input aimed at this output
    for (genvar i = 0; i < noc_pkg::NumPorts; i++) begin : gen_req
      assign out_req[o][i] = route[i][o];
    end

    noc_packet_arbiter u_arb (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (out_req[o]),
      .last_i      (head_last),
      .out_ready_i (out_ready_i[o]),
      .gnt_o       (gnt[o])
    );

    // Valid only when the granted input really requests this output
    // a held grant may point at an input whose queue ran dry
    assign out_valid_o[o] = |(gnt[o] & out_req[o]);

  end

  // One-hot grant selects the head flit for each output
  always_comb begin
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      out_flit_o[o] = '0;
      for (int i = 0; i < noc_pkg::NumPorts; i++) begin
        if (gnt[o][i]) begin
          out_flit_o[o] = head_flit[i];
        end
      end
    end
  end

  // Pop an input when its granted output accepts the flit
  // Request term keeps a stale grant from popping an empty queue
  always_comb begin
    for (int i = 0; i < noc_pkg::NumPorts; i++) begin
      pop[i] = 1'b0;
      for (int o = 0; o < noc_pkg::NumPorts; o++) begin
        if (gnt[o][i] && out_req[o][i] && out_ready_i[o]) begin
          pop[i] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/noc_router_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output channel properties of the router
// Bound into noc_router from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_router_checker (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] out_flit_o,
  input  logic           [noc_pkg::NumPorts-1:0] out_valid_o,
  input  logic           [noc_pkg::NumPorts-1:0] out_ready_i,
  input  logic           [noc_pkg::NumPorts-1:0] in_ready_o
);

  // Reset leaves all outputs idle and all queues open
  assert property (@(posedge clk_i) reset_i |=> (out_valid_o == '0) && (&in_ready_o))
    else $error("output valid or input ready wrong after reset");

  for (genvar o = 0; o < noc_pkg::NumPorts; o++) begin : gen_port
    // Stalled flit is held unchanged until taken
    assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid_o[o] && !out_ready_i[o] |=> out_valid_o[o] && $stable(out_flit_o[o]))
      else $error("output %0d changed while stalled", o);
  end

endmodule

`default_nettype wire

/* verification/noc_router_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the mesh router at tile (3,4)
// Random packets, back-pressure and fairness
// Scoreboard per source and output pair
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_router_tb;

  localparam int NP = noc_pkg::NumPorts;
  // Cycles allowed for any single wait
  localparam int Timeout = 2000;

  logic clk_i = 1'b0;
  logic reset_i;
  noc_pkg::xy_coord_t xy_id;
  noc_pkg::flit_t [NP-1:0] in_flit;
  noc_pkg::flit_t [NP-1:0] out_flit;
  logic [NP-1:0] in_valid;
  logic [NP-1:0] in_ready;
  logic [NP-1:0] out_valid;
  logic [NP-1:0] out_ready;
  // Forces an output to stall
  logic [NP-1:0] hold_low;
  logic fair_phase;
  integer seed = 32'h6618;

  // Expected flits indexed by source * NP + output
  noc_pkg::flit_t exp_q [NP*NP][$];
  int unsigned seq [NP];
  int unsigned sent [NP];
  int unsigned skipped [NP];
  int cur_src [NP];
  logic in_pkt [NP];

  always #50 clk_i = ~clk_i;

  noc_router dut0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .xy_id_i     (xy_id),
    .in_flit_i   (in_flit),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .out_flit_o  (out_flit),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  bind noc_router noc_router_checker u_checker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o)
  );

  // XY order takes x first, then y, and ejects on arrival
  function automatic noc_pkg::port_e expected_port(noc_pkg::xy_coord_t dst,
                                                   noc_pkg::xy_coord_t here);
    if (dst == here) begin
      return noc_pkg::Eject;
    end
    if (dst.x == here.x) begin
      return (dst.y < here.y) ? noc_pkg::South : noc_pkg::North;
    end
    return (dst.x < here.x) ? noc_pkg::West : noc_pkg::East;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_flit(string name, noc_pkg::flit_t got, noc_pkg::flit_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_port(string name, noc_pkg::port_e got, noc_pkg::port_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      abort_run();
    end
  endtask

  // Leaves valid high after the last flit until the caller idles the channel
  task automatic send_packet(int p, noc_pkg::xy_coord_t dst, int len);
    noc_pkg::flit_t f;
    int t;
    for (int k = 0; k < len; k++) begin
      f.dst     = dst;
      // Source port on top, sequence number below
      f.payload = {3'(p), 13'(seq[p])};
      f.last    = (k == len - 1);
      @(negedge clk_i);
      in_flit[p]  = f;
      in_valid[p] = 1'b1;
      t = 0;
      while (!in_ready[p]) begin
        t++;
        if (t > Timeout) begin
          $display("Input %0d was never ready to accept a flit", p);
          abort_run();
        end
        @(negedge clk_i);
      end
      // Ready is stable here so the flit transfers at the next rising edge
      exp_q[p * NP + int'(expected_port(dst, xy_id))].push_back(f);
      seq[p]++;
      sent[p]++;
    end
  endtask

  task automatic go_idle(int p, int n);
    repeat (n) begin
      @(negedge clk_i);
      in_valid[p] = 1'b0;
    end
  endtask

  task automatic drive_random(int p, int n);
    noc_pkg::xy_coord_t dst;
    for (int k = 0; k < n; k++) begin
      dst.x = 3'($random(seed));
      dst.y = 3'($random(seed));
      // Every third packet stays in this column
      if (k % 3 == 0) begin
        dst.x = xy_id.x;
      end
      // The packet after it stays in this row
      if (k % 3 == 1) begin
        dst.y = xy_id.y;
      end
      send_packet(p, dst, 1 + ($random(seed) & 3));
      go_idle(p, 1 + ($random(seed) & 3));
    end
  endtask

  // Back-to-back packets towards the local tile
  task automatic drive_fair(int p, int n);
    for (int k = 0; k < n; k++) begin
      send_packet(p, xy_id, 1 + ($random(seed) & 3));
    end
    go_idle(p, 1);
  endtask

  task automatic check_flit(int o, noc_pkg::flit_t f);
    int src;
    string name;
    src  = int'(f.payload[15:13]);
    name = $sformatf("out_flit_o[%0d]", o);
    compare_port({name, " port"}, noc_pkg::port_e'(o), expected_port(f.dst, xy_id));
    if (src >= NP || exp_q[src * NP + o].size() == 0) begin
      $display("Flit %h on output %0d was never sent", f, o);
      abort_run();
    end
    if (in_pkt[o]) begin
      compare_port({name, " source"}, noc_pkg::port_e'(src), noc_pkg::port_e'(cur_src[o]));
    end
    compare_flit(name, f, exp_q[src * NP + o].pop_front());
    // Packet start on eject counts waiting sources
    if (!in_pkt[o] && fair_phase && o == int'(noc_pkg::Eject)) begin
      for (int s = 1; s < NP; s++) begin
        if (s == src) begin
          skipped[s] = 0;
        end else if (exp_q[s * NP].size() != 0) begin
          skipped[s]++;
        end
        if (skipped[s] > 4) begin
          $display("Input %0d waited more than four packets for eject", s);
          abort_run();
        end
      end
    end
    cur_src[o] = src;
    in_pkt[o]  = !f.last;
  endtask

  // Random ready, then check what the next rising edge takes
  task automatic watch_output(int o);
    forever begin
      @(negedge clk_i);
      out_ready[o] = !hold_low[o] && (($random(seed) & 3) != 0);
      if (!reset_i && out_valid[o] && out_ready[o]) begin
        check_flit(o, out_flit[o]);
      end
    end
  endtask

  task automatic wait_drain();
    int t;
    int total;
    t = 0;
    do begin
      @(negedge clk_i);
      total = 0;
      foreach (exp_q[i]) begin
        total += exp_q[i].size();
      end
      t++;
      if (t > Timeout) begin
        $display("Scoreboards still hold %0d flits", total);
        abort_run();
      end
    end while (total != 0);
  endtask

  // With East stalled the West input closes after two flits
  task automatic check_backpressure();
    noc_pkg::xy_coord_t dst;
    int t;
    int base;
    dst.x = 3'd6;
    dst.y = 3'd1;
    hold_low[noc_pkg::East] = 1'b1;
    base = sent[noc_pkg::West];
    fork
      begin
        send_packet(noc_pkg::West, dst, 4);
        go_idle(noc_pkg::West, 1);
      end
      begin
        t = 0;
        do begin
          @(negedge clk_i);
          t++;
          if (t > Timeout) begin
            $display("West input stayed ready under a stalled output");
            abort_run();
          end
        end while (in_ready[noc_pkg::West]);
        if (sent[noc_pkg::West] - base != 2) begin
          $display("[ERROR] %0t in_ready_o[2] fell after %0d flits expected 2", $time,
                   sent[noc_pkg::West] - base);
          abort_run();
        end
        hold_low[noc_pkg::East] = 1'b0;
      end
    join
  endtask

  initial begin
    reset_i    = 1'b1;
    xy_id.x    = 3'd3;
    xy_id.y    = 3'd4;
    in_flit    = '0;
    in_valid   = '0;
    out_ready  = '0;
    hold_low   = '0;
    fair_phase = 1'b0;
    for (int i = 0; i < NP; i++) begin
      seq[i]     = 0;
      sent[i]    = 0;
      skipped[i] = 0;
      cur_src[i] = 0;
      in_pkt[i]  = 1'b0;
    end
    for (int o = 0; o < NP; o++) begin
      fork
        automatic int oo = o;
        watch_output(oo);
      join_none
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    check_backpressure();
    wait_drain();
    fork
      drive_random(0, 10);
      drive_random(1, 10);
      drive_random(2, 10);
      drive_random(3, 10);
      drive_random(4, 10);
    join
    wait_drain();
    fair_phase = 1'b1;
    fork
      drive_fair(1, 6);
      drive_fair(2, 6);
      drive_fair(3, 6);
      drive_fair(4, 6);
    join
    wait_drain();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
common/noc_pkg.sv
src/noc_input_fifo.sv
src/noc_route_select.sv
src/noc_packet_arbiter.sv
router/noc_router.sv
verification/noc_router_checker.sv
verification/noc_router_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module noc_router_tb \
  -Mdir build \
  -f flist.f

./build/Vnoc_router_tb
